/* common/bus_pkg.sv */
package bus_pkg;

	// register page offsets.
	localparam logic [7:0] addr_div  = 8'h04;
	localparam logic [7:0] addr_tima = 8'h05;
	localparam logic [7:0] addr_tma  = 8'h06;
	localparam logic [7:0] addr_tac  = 8'h07;
	localparam logic [7:0] addr_if   = 8'h0f;
	localparam logic [7:0] addr_ie   = 8'hff;

	// one bus cycle as seen by the register blocks.
	typedef struct packed {
		logic       wr;
		logic       rd;
		logic [7:0] addr;
		logic [7:0] wdata;
	} bus_req_t;

endpackage

/* common/irq_pkg.sv */
package irq_pkg;

	localparam int irq_num = 5;

	// bit position is also priority, lowest index wins.
	localparam logic [2:0] irq_bit_vblank = 3'd0;
	localparam logic [2:0] irq_bit_stat   = 3'd1;
	localparam logic [2:0] irq_bit_timer  = 3'd2;
	localparam logic [2:0] irq_bit_serial = 3'd3;
	localparam logic [2:0] irq_bit_joypad = 3'd4;

	// first field is the most significant bit.
	typedef struct packed {
		logic joypad;
		logic serial;
		logic timer;
		logic stat;
		logic vblank;
	} irq_src_t;

	// vectors step by 8 from here.
	localparam logic [7:0] irq_vector_base = 8'h40;

	// IF bits above the sources read back as ones.
	localparam logic [7-irq_num:0] if_unused_ones = '1;

	// divider bit that clocks TIMA, indexed by TAC[1:0].
	localparam int tac_div_bit [4] = '{9, 3, 5, 7};

	localparam int joy_filter_len = 4;

endpackage

/* irq/irq_dispatch.sv */
`timescale 1ns/100ps

module irq_dispatch
	import irq_pkg::*;
(
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  irq_src_t   flags,
	input  irq_src_t   enables,
	input  logic       cpu_ack,
	output irq_src_t   clr,
	output irq_src_t   irq_trig,
	output logic [7:0] irq_vector
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_release
	} state_t;

	state_t     state;
	irq_src_t   pending;
	logic [2:0] sel_idx;
	logic [7:0] sel_vector;

	assign pending = flags & enables;

	// fixed priority, vblank first.
	always_comb begin
		if (pending.vblank) begin
			sel_idx = irq_bit_vblank;
		end else if (pending.stat) begin
			sel_idx = irq_bit_stat;
		end else if (pending.timer) begin
			sel_idx = irq_bit_timer;
		end else if (pending.serial) begin
			sel_idx = irq_bit_serial;
		end else begin
			sel_idx = irq_bit_joypad;
		end
	end

	assign sel_vector = irq_vector_base + {2'b00, sel_idx, 3'b000};

	// clear goes out in the ack cycle so IF drops at the ack edge.
	assign clr = (state == st_request && cpu_ack) ? irq_trig : irq_src_t'('0);

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			state      <= st_idle;
			irq_trig   <= '0;
			irq_vector <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (|pending) begin
						irq_trig   <= irq_src_t'(5'b00001 << sel_idx);
						irq_vector <= sel_vector;
						state      <= st_request;
					end
				end
				st_request: begin
					// hold the trigger until the cpu takes it.
					if (cpu_ack) begin
						irq_trig <= '0;
						state    <= st_release;
					end
				end
				st_release: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

/* irq/irq_flags.sv */
`timescale 1ns/100ps

module irq_flags
	import bus_pkg::*;
	import irq_pkg::*;
(
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  bus_req_t   bus,
	input  irq_src_t   req,
	input  irq_src_t   clr,
	output irq_src_t   flags,
	output logic [7:0] enables,
	output logic [7:0] flags_rdata
);

	logic     if_wr;
	logic     ie_wr;
	irq_src_t flags_next;

	assign if_wr = bus.wr && (bus.addr == addr_if);
	assign ie_wr = bus.wr && (bus.addr == addr_ie);

	// a write replaces the flags, otherwise ack clears.
	// requests land on top either way, so set beats clear.
	always_comb begin
		if (if_wr) begin
			flags_next = irq_src_t'(bus.wdata[irq_num-1:0]);
		end else begin
			flags_next = flags & ~clr;
		end
		flags_next = flags_next | req;
	end

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			flags <= '0;
		end else begin
			flags <= flags_next;
		end
	end

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			enables <= '0;
		end else if (ie_wr) begin
			enables <= bus.wdata;
		end
	end

	// read-back, zero outside our two addresses.
	always_comb begin
		flags_rdata = '0;
		if (bus.rd) begin
			case (bus.addr)
				addr_if: flags_rdata = {if_unused_ones, flags};
				addr_ie: flags_rdata = enables;
				default: flags_rdata = '0;
			endcase
		end
	end

endmodule

/* rtl/input_sync.sv */
`timescale 1ns/100ps

module input_sync #(
	parameter type payload_t = logic
) (
	input  logic     boga1mhz,
	input  logic     rst_n,
	input  payload_t din,
	output payload_t dout
);

	payload_t meta;

	// two stages before anything downstream looks at it.
	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			meta <= '0;
			dout <= '0;
		end else begin
			meta <= din;
			dout <= meta;
		end
	end

endmodule

/* rtl/irq_subsystem.sv */
`timescale 1ns/100ps

module irq_subsystem
	import bus_pkg::*;
	import irq_pkg::*;
(
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  bus_req_t   bus,
	input  irq_src_t   src,
	input  logic [3:0] keys,
	input  logic       cpu_ack,
	output logic [7:0] rdata,
	output irq_src_t   irq_trig,
	output logic [7:0] irq_vector,
	output logic       wake
);

	irq_src_t   src_q;
	logic [3:0] keys_q;
	logic       joy_req;
	logic       timer_req;
	logic [7:0] timer_rdata;
	logic [7:0] flags_rdata;
	logic [7:0] enables;
	irq_src_t   req;
	irq_src_t   flags;
	irq_src_t   clr;

	input_sync #(.payload_t(irq_src_t)) src_sync_inst (
		.boga1mhz (boga1mhz),
		.rst_n    (rst_n),
		.din      (src),
		.dout     (src_q)
	);

	input_sync #(.payload_t(logic [3:0])) keys_sync_inst (
		.boga1mhz (boga1mhz),
		.rst_n    (rst_n),
		.din      (keys),
		.dout     (keys_q)
	);

	joypad_detect joypad_detect_inst (
		.boga1mhz (boga1mhz),
		.rst_n    (rst_n),
		.keys     (keys_q),
		.joy_req  (joy_req),
		.wake     (wake)
	);

	irq_timer irq_timer_inst (
		.boga1mhz    (boga1mhz),
		.rst_n       (rst_n),
		.bus         (bus),
		.timer_rdata (timer_rdata),
		.timer_req   (timer_req)
	);

	// timer and joypad come from inside, the rest from outside.
	assign req = '{
		joypad: joy_req,
		serial: src_q.serial,
		timer:  timer_req,
		stat:   src_q.stat,
		vblank: src_q.vblank
	};

	irq_flags irq_flags_inst (
		.boga1mhz    (boga1mhz),
		.rst_n       (rst_n),
		.bus         (bus),
		.req         (req),
		.clr         (clr),
		.flags       (flags),
		.enables     (enables),
		.flags_rdata (flags_rdata)
	);

	irq_dispatch irq_dispatch_inst (
		.boga1mhz   (boga1mhz),
		.rst_n      (rst_n),
		.flags      (flags),
		.enables    (irq_src_t'(enables[irq_num-1:0])),
		.cpu_ack    (cpu_ack),
		.clr        (clr),
		.irq_trig   (irq_trig),
		.irq_vector (irq_vector)
	);

	// both sides are zero outside their own addresses.
	assign rdata = flags_rdata | timer_rdata;

endmodule

/* rtl/joypad_detect.sv */
`timescale 1ns/100ps

module joypad_detect
	import irq_pkg::*;
(
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  logic [3:0] keys,
	output logic       joy_req,
	output logic       wake
);

	// stage 0 is the registered key OR.
	logic [joy_filter_len-1:0] stage;
	logic                      last_q;

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			stage  <= '0;
			last_q <= 1'b0;
		end else begin
			stage  <= {stage[joy_filter_len-2:0], |keys};
			last_q <= stage[joy_filter_len-1];
		end
	end

	assign wake = stage[0];

	// fires once as the last stage rises, keys still down.
	assign joy_req = stage[joy_filter_len-1] && !last_q && stage[0];

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_irq_subsystem

out=$(./obj_dir/Vtb_irq_subsystem)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

/* tb.f */
+incdir+testbench
common/bus_pkg.sv
common/irq_pkg.sv
rtl/input_sync.sv
rtl/joypad_detect.sv
timer/irq_timer.sv
irq/irq_flags.sv
irq/irq_dispatch.sv
rtl/irq_subsystem.sv
testbench/tb_irq_subsystem.sv

/* testbench/irq_stimulus.txt */
# columns: operation, operand a, operand b; numbers in hex
# wr addr data | rd addr expected | src bits | key bits cycles | wake level | ack vector
# quiet cycles | idle cycles | test number
test 1
rd 0f e0
rd ff 00
rd 07 f8
wr ff 1f
wr 0f 15
rd ff 1f
rd 0f f5
wr ff 00
wr 0f 00
ack 40
rd 0f e0
test 2
wr ff 00
src 08
idle 2
rd 0f e8
wr 0f 00
rd 0f e0
test 3
wr ff 1f
src 0a
ack 48
ack 58
rd 0f e0
test 4
wr ff 04
src 01
idle 2
rd 0f e1
quiet 20
wr ff 05
ack 40
rd 0f e0
test 5
wr ff 04
wr 06 fe
wr 05 fe
rd 05 fe
wr 07 05
rd 07 fd
ack 50
rd 05 fe
wr 07 00
test 6
wr 0f 00
wr ff 1f
key 04 02
idle 1
wake 01
quiet 20
wake 00
key 04 06
ack 60
rd 0f e0

/* testbench/tb_tasks.svh */
`ifndef tb_tasks_svh
`define tb_tasks_svh

task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		$display("FAILED at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
		error_count++;
		test_errors++;
	end
endtask

task automatic report_problem(input string what);
	$display("ERROR at %0t ns: %s", $time, what);
	error_count++;
	test_errors++;
endtask

// returns on the falling edge where a trigger is up.
task automatic wait_for_trigger(input int limit, output logic seen);
	int n;
	seen = 1'b0;
	n = 0;
	while (!seen && n < limit) begin
		if (irq_trig != '0) begin
			seen = 1'b1;
		end else begin
			@(negedge boga1mhz);
			n++;
		end
	end
endtask

task automatic expect_quiet(input int cycles);
	int   n;
	logic fired;
	fired = 1'b0;
	for (n = 0; n < cycles; n++) begin
		if (irq_trig != '0) begin
			fired = 1'b1;
		end
		@(negedge boga1mhz);
	end
	if (fired) begin
		report_problem("a trigger came up while none was expected");
	end
endtask

task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
	bus = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
	@(negedge boga1mhz);
	bus = '0;
endtask

// read data is combinational, so sample well before the next edge.
task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
	bus = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 8'h00};
	#1;
	data = rdata;
	@(negedge boga1mhz);
	bus = '0;
endtask

`endif

/* testbench/tb_irq_subsystem.sv */
`timescale 1ns/100ps

module tb_irq_subsystem
	import bus_pkg::*;
	import irq_pkg::*;
();

	localparam int trig_timeout = 200;

	logic       boga1mhz;
	logic       rst_n;
	bus_req_t   bus;
	irq_src_t   src;
	logic [3:0] keys;
	logic       cpu_ack;
	logic [7:0] rdata;
	irq_src_t   irq_trig;
	logic [7:0] irq_vector;
	logic       wake;

	int error_count;
	int test_errors;
	int test_count;
	int failed_tests;
	int current_test;

	// IF and IE as software should see them.
	logic [4:0] model_if;
	logic [7:0] model_ie;

	irq_subsystem irq_subsystem_inst (
		.boga1mhz   (boga1mhz),
		.rst_n      (rst_n),
		.bus        (bus),
		.src        (src),
		.keys       (keys),
		.cpu_ack    (cpu_ack),
		.rdata      (rdata),
		.irq_trig   (irq_trig),
		.irq_vector (irq_vector),
		.wake       (wake)
	);

	`include "tb_tasks.svh"

	initial begin
		boga1mhz = 1'b0;
		forever begin
			#2 boga1mhz = ~boga1mhz;
		end
	end

	task automatic finish_test();
		if (current_test != 0) begin
			if (test_errors == 0) begin
				$display("test %0d: ok", current_test);
			end else begin
				$display("test %0d: %0d errors", current_test, test_errors);
				failed_tests++;
			end
		end
	endtask

	// vblank, stat and serial only.
	task automatic pulse_source(input logic [4:0] bits);
		src = irq_src_t'(bits);
		@(negedge boga1mhz);
		src = '0;
		model_if = model_if | (bits & 5'b01011);
	endtask

	task automatic hold_keys(input logic [3:0] bits, input logic [31:0] cycles);
		keys = bits;
		repeat (cycles) @(negedge boga1mhz);
		keys = '0;
	endtask

	// expected trigger bit follows from the vector spacing of 8.
	task automatic take_interrupt(input logic [7:0] vector);
		logic     seen;
		irq_src_t exp_trig;
		exp_trig = irq_src_t'(5'b00001 << ((vector - irq_vector_base) >> 3));
		wait_for_trigger(trig_timeout, seen);
		if (!seen) begin
			report_problem($sformatf("no trigger came up for vector %02h", vector));
		end else begin
			check_value("irq_vector", irq_vector, vector);
			check_value("irq_trig", {3'b000, irq_trig}, {3'b000, exp_trig});
			cpu_ack = 1'b1;
			@(negedge boga1mhz);
			cpu_ack = 1'b0;
			check_value("irq_trig after ack", {3'b000, irq_trig}, 8'h00);
			model_if = model_if & ~exp_trig;
		end
	endtask

	task automatic run_op(input logic [63:0] op, input logic [31:0] a, input logic [31:0] b);
		logic [7:0] got;
		case (op)
			"test": begin
				finish_test();
				current_test = a;
				test_count++;
				test_errors = 0;
			end
			"wr": begin
				bus_write(a[7:0], b[7:0]);
				if (a[7:0] == addr_if) begin
					model_if = b[4:0];
				end
				if (a[7:0] == addr_ie) begin
					model_ie = b[7:0];
				end
			end
			"rd": begin
				bus_read(a[7:0], got);
				check_value($sformatf("rdata at %02h", a[7:0]), got, b[7:0]);
				if (a[7:0] == addr_if) begin
					check_value("IF model", {3'b111, model_if}, b[7:0]);
				end
				if (a[7:0] == addr_ie) begin
					check_value("IE model", model_ie, b[7:0]);
				end
			end
			"src":   pulse_source(a[4:0]);
			"key":   hold_keys(a[3:0], b);
			"wake":  check_value("wake", {7'd0, wake}, a[7:0]);
			"ack":   take_interrupt(a[7:0]);
			"quiet": expect_quiet(a);
			"idle":  repeat (a) @(negedge boga1mhz);
			default: report_problem($sformatf("unknown operation %0s in the stimulus file", op));
		endcase
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		logic [63:0] op;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		rst_n = 1'b0;
		bus = '0;
		src = '0;
		keys = '0;
		cpu_ack = 1'b0;
		error_count = 0;
		test_errors = 0;
		test_count = 0;
		failed_tests = 0;
		current_test = 0;
		model_if = '0;
		model_ie = '0;
		repeat (5) @(negedge boga1mhz);
		rst_n = 1'b1;
		@(negedge boga1mhz);
		fd = $fopen("testbench/irq_stimulus.txt", "r");
		if (fd == 0) begin
			report_problem("the stimulus file could not be opened");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				op = '0;
				arg_a = '0;
				arg_b = '0;
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %h %h", op, arg_a, arg_b);
					run_op(op, arg_a, arg_b);
				end
			end
			$fclose(fd);
		end
		finish_test();
		$display("tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* timer/irq_timer.sv */
`timescale 1ns/100ps

module irq_timer
	import bus_pkg::*;
	import irq_pkg::*;
(
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  bus_req_t   bus,
	output logic [7:0] timer_rdata,
	output logic       timer_req
);

	logic [15:0] div_cnt;
	logic [7:0]  tima;
	logic [7:0]  tma;
	logic [2:0]  tac;
	logic        div_bit;
	logic        div_bit_q;
	logic        tick;

	// any write to DIV restarts the whole divider.
	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (bus.wr && bus.addr == addr_div) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 16'd1;
		end
	end

	assign div_bit = div_cnt[tac_div_bit[tac[1:0]]];

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			div_bit_q <= 1'b0;
		end else begin
			div_bit_q <= div_bit;
		end
	end

	// falling edge of the selected bit.
	assign tick = div_bit_q && !div_bit && tac[2];

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			tma <= '0;
			tac <= '0;
		end else if (bus.wr) begin
			if (bus.addr == addr_tma) begin
				tma <= bus.wdata;
			end
			if (bus.addr == addr_tac) begin
				tac <= bus.wdata[2:0];
			end
		end
	end

	always_ff @(posedge boga1mhz) begin
		if (!rst_n) begin
			tima      <= '0;
			timer_req <= 1'b0;
		end else begin
			timer_req <= 1'b0;
			if (bus.wr && bus.addr == addr_tima) begin
				tima <= bus.wdata;
			end else if (tick) begin
				if (tima == 8'hff) begin
					// overflow reloads and requests in the same edge.
					tima      <= tma;
					timer_req <= 1'b1;
				end else begin
					tima <= tima + 8'd1;
				end
			end
		end
	end

	always_comb begin
		timer_rdata = '0;
		if (bus.rd) begin
			case (bus.addr)
				addr_div:  timer_rdata = div_cnt[15:8];
				addr_tima: timer_rdata = tima;
				addr_tma:  timer_rdata = tma;
				addr_tac:  timer_rdata = {5'b11111, tac};
				default:   timer_rdata = '0;
			endcase
		end
	end

endmodule
